// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_subsystem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/id_monitor.sv
// Scoreboard for the decode subsystem. Expects writebacks only while the pipeline is empty.
// Decode class comes from the stimulus, operands from a shadow copy of the register file.
`default_nettype none
`timescale 1ns/1ps

module id_monitor (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic [id_pkg::XLEN-1:0]   instr_i,
  input  logic                      instr_valid_i,
  input  logic                      dummy_i,
  input  logic                      id_ready_i,
  input  logic                      kill_i,
  input  logic                      wb_we_i,
  input  logic [id_pkg::REG_AW-1:0] wb_addr_i,
  input  logic [id_pkg::XLEN-1:0]   wb_data_i,
  input  logic                      ex_ready_i,
  input  logic                      id_valid_i,
  input  logic [2:0]                ex_unit_i,
  input  logic [2:0]                ex_sys_op_i,
  input  logic [1:0]                ex_csr_op_i,
  input  logic                      ex_lsu_we_i,
  input  logic                      ex_rf_we_i,
  input  logic [id_pkg::REG_AW-1:0] ex_rd_i,
  input  logic [id_pkg::XLEN-1:0]   ex_operand_a_i,
  input  logic [id_pkg::XLEN-1:0]   ex_operand_b_i,
  input  logic                      ex_illegal_i,
  // Expected decode class, held by the testbench together with the fetch word
  input  logic [2:0]                exp_unit_i,
  input  logic [2:0]                exp_sys_op_i,
  input  logic [1:0]                exp_csr_op_i,
  input  logic                      exp_illegal_i,
  output logic                      idle_o,
  output int                        value_errors_o,
  output int                        protocol_errors_o
);

  // One entry is {unit, sys_op, csr_op, lsu_we, rf_we, rd, operand_a, operand_b, illegal}
  logic [79:0]             expect_q [$];
  logic [id_pkg::XLEN-1:0] shadow [id_pkg::NUM_REGS];

  assign idle_o = (expect_q.size() == 0);

  initial begin
    value_errors_o    = 0;
    protocol_errors_o = 0;
    for (int i = 0; i < id_pkg::NUM_REGS; i++) begin
      shadow[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model of operand selection
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] read_reg(input logic [4:0] addr, input logic dummy);
    if (addr == 5'd0 && !dummy) begin
      return 32'd0;
    end
    return shadow[addr];
  endfunction

  // Immediate by format, and whether operand B takes it
  function automatic logic [32:0] pick_imm(input logic [31:0] instr);
    case (instr[6:0])
      7'h13, 7'h03: return {1'b1, {20{instr[31]}}, instr[31:20]};
      7'h23:        return {1'b1, {20{instr[31]}}, instr[31:25], instr[11:7]};
      7'h37:        return {1'b1, instr[31:12], 12'b0};
      // CSR forms put the CSR address on operand B
      7'h73:        return (instr[14:12] != 3'd0) ? {1'b1, 20'b0, instr[31:20]} : 33'd0;
      default:      return 33'd0;
    endcase
  endfunction

  function automatic logic [79:0] predict(input logic [31:0] instr, input logic dummy);
    logic [32:0] imm;
    logic [4:0]  rs1;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        lsu_we;
    logic        rf_we;
    logic [6:0]  opc;
    opc  = instr[6:0];
    imm  = pick_imm(instr);
    // LUI has no rs1 field and reads register 0
    rs1  = (opc == 7'h37) ? 5'd0 : instr[19:15];
    op_a = read_reg(rs1, dummy);
    op_b = imm[32] ? imm[31:0] : read_reg(instr[24:20], dummy);
    lsu_we = !exp_illegal_i && (opc == 7'h23);
    rf_we  = !exp_illegal_i && (opc == 7'h33 || opc == 7'h13 || opc == 7'h03 ||
                                opc == 7'h37 || (opc == 7'h73 && instr[14:12] != 3'd0));
    return {exp_unit_i, exp_sys_op_i, exp_csr_op_i, lsu_we, rf_we, instr[11:7],
            op_a, op_b, exp_illegal_i};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      value_errors_o++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sampling at the clock edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [79:0] e;
    if (!reset_i) begin
      // Output side first, since a word never leaves in the cycle it enters
      if (id_valid_i && ex_ready_i) begin
        if (expect_q.size() == 0) begin
          protocol_errors_o++;
          $display("Result delivered at %0t ns with no word outstanding", $time);
        end else begin
          e = expect_q.pop_front();
          compare("ex_unit_o", e[79:77], ex_unit_i);
          compare("ex_sys_op_o", e[76:74], ex_sys_op_i);
          compare("ex_csr_op_o", e[73:72], ex_csr_op_i);
          compare("ex_lsu_we_o", e[71], ex_lsu_we_i);
          compare("ex_rf_we_o", e[70], ex_rf_we_i);
          compare("ex_rd_o", e[69:65], ex_rd_i);
          compare("ex_operand_a_o", e[64:33], ex_operand_a_i);
          compare("ex_operand_b_o", e[32:1], ex_operand_b_i);
          compare("ex_illegal_o", e[0], ex_illegal_i);
        end
      end
      if (kill_i) begin
        // Everything still in flight is flushed
        expect_q.delete();
      end else if (instr_valid_i && id_ready_i) begin
        expect_q.push_back(predict(instr_i, dummy_i));
      end
      if (wb_we_i) begin
        shadow[wb_addr_i] <= wb_data_i;
      end
    end
  end

  // Called once the stimulus is done
  task automatic check_drained();
    if (expect_q.size() != 0) begin
      protocol_errors_o++;
      $display("%0d accepted words never came out of the stage", expect_q.size());
    end
  endtask

endmodule

`default_nettype wire

// File: sim/id_stage_checker.sv
// Concurrent properties on id_stage control, bound into every id_stage instance.
`default_nettype none
`timescale 1ns/1ps

module id_stage_checker (
  input logic                      clk,
  input logic                      reset_i,
  input logic                      halt_i,
  input logic                      kill_i,
  input logic                      id_ready_i,
  input logic                      id_valid_i,
  input logic                      advance_i,
  input logic                      dummy_i,
  input logic [id_pkg::REG_AW-1:0] rs1_i,
  input id_pkg::id_ex_t            id_ex_i
);

  // Running count of failed properties
  int fail_count = 0;

  // Halt without kill freezes both handshakes
  assert property (@(posedge clk) disable iff (reset_i)
    (halt_i && !kill_i) |-> (!id_ready_i && !id_valid_i))
    else begin
      fail_count++;
      $error("Handshake active during halt");
    end

  assert property (@(posedge clk) disable iff (reset_i)
    kill_i |-> (id_ready_i && !id_valid_i))
    else begin
      fail_count++;
      $error("Wrong handshake during kill");
    end

  // An illegal result must not start any unit
  assert property (@(posedge clk) disable iff (reset_i)
    (id_valid_i && id_ex_i.illegal) |-> (id_ex_i.unit == id_pkg::UNIT_NONE &&
      id_ex_i.sys_op == id_pkg::SYS_NONE && id_ex_i.csr_op == id_pkg::CSR_OP_READ &&
      !id_ex_i.rf_we && !id_ex_i.lsu_we))
    else begin
      fail_count++;
      $error("Illegal word carries a side effect");
    end

  // The ID/EX register captures a zero operand A for an ordinary word with rs1 of 0
  assert property (@(posedge clk) disable iff (reset_i)
    (advance_i && rs1_i == '0 && !dummy_i) |=> (id_ex_i.operand_a == '0))
    else begin
      fail_count++;
      $error("Operand A not zero for register 0");
    end

endmodule

bind id_stage id_stage_checker id_stage_checker_i (
  .clk        (clk),
  .reset_i    (reset_i),
  .halt_i     (halt_i),
  .kill_i     (kill_i),
  .id_ready_i (id_ready_o),
  .id_valid_i (id_valid_o),
  .advance_i  (advance),
  .dummy_i    (if_id_q.dummy),
  .rs1_i      (raddr_o[0]),
  .id_ex_i    (id_ex_o)
);

`default_nettype wire

// File: sim/id_stimulus.txt
# kind: 0 writeback (addr data), 1 fetch (instr dummy), 2 halt (cycles), 3 kill
# columns: kind a1 a2 unit sys_op csr_op illegal, all hex
0 01 11111111 0 0 0 0
0 02 22222222 0 0 0 0
0 03 0000abcd 0 0 0 0
1 002082b3 0 1 0 0 0
1 02208333 0 2 0 0 0
1 0220c3b3 0 3 0 0 0
1 fff18413 0 1 0 0 0
1 0080a483 0 6 0 0 0
1 0020a223 0 6 0 0 0
1 12345537 0 1 0 0 0
1 300095f3 0 4 0 1 0
1 30012673 0 4 0 2 0
1 3001b6f3 0 4 0 3 0
1 30002773 0 4 0 0 0
2 5 0 0 0 0 0
1 00000073 0 5 1 0 0
1 00100073 0 5 2 0 0
1 30200073 0 5 3 0 0
1 10500073 0 5 4 0 0
1 0000100f 0 5 5 0 0
1 0000007f 0 0 0 0 1
1 0020807b 0 0 0 0 1
0 00 deadbeef 0 0 0 0
1 000007b3 0 1 0 0 0
1 000007b3 1 1 0 0 0
1 002082b3 0 1 0 0 0
1 02208333 0 2 0 0 0
3 0 0 0 0 0 0
1 0220c3b3 1 3 0 0 0
1 0080a483 1 6 0 0 0

// File: sim/id_subsystem_tb.sv
// Testbench for id_subsystem, run from the project root so the stimulus path resolves.
// EX back-pressure is random; writebacks wait until the pipeline has drained.
`default_nettype none
`timescale 1ns/1ps

module id_subsystem_tb;

  logic        clk = 1'b0;
  logic        reset_i = 1'b1;
  logic [31:0] instr_i = '0;
  logic        instr_valid_i = 1'b0;
  logic        dummy_i = 1'b0;
  logic        halt_i = 1'b0;
  logic        kill_i = 1'b0;
  logic        wb_we_i = 1'b0;
  logic [4:0]  wb_addr_i = '0;
  logic [31:0] wb_data_i = '0;
  logic        ex_ready_i = 1'b0;
  logic [2:0]  exp_unit = '0;
  logic [2:0]  exp_sys_op = '0;
  logic [1:0]  exp_csr_op = '0;
  logic        exp_illegal = 1'b0;

  logic        id_ready_o;
  logic        id_valid_o;
  id_pkg::unit_e   ex_unit_o;
  id_pkg::sys_op_e ex_sys_op_o;
  id_pkg::csr_op_e ex_csr_op_o;
  logic        ex_lsu_we_o;
  logic        ex_rf_we_o;
  logic [4:0]  ex_rd_o;
  logic [31:0] ex_operand_a_o;
  logic [31:0] ex_operand_b_o;
  logic        ex_illegal_o;

  logic        mon_idle;
  int          value_errors;
  int          protocol_errors;
  int          tb_errors = 0;
  logic [31:0] lfsr = 32'h2132b6a7;

  always #2 clk = ~clk;

  id_subsystem id_subsystem_i (.*);

  // Taps on the DUT ports
  id_monitor id_monitor_i (
    .clk               (clk),
    .reset_i           (id_subsystem_i.reset_i),
    .instr_i           (id_subsystem_i.instr_i),
    .instr_valid_i     (id_subsystem_i.instr_valid_i),
    .dummy_i           (id_subsystem_i.dummy_i),
    .id_ready_i        (id_subsystem_i.id_ready_o),
    .kill_i            (id_subsystem_i.kill_i),
    .wb_we_i           (id_subsystem_i.wb_we_i),
    .wb_addr_i         (id_subsystem_i.wb_addr_i),
    .wb_data_i         (id_subsystem_i.wb_data_i),
    .ex_ready_i        (id_subsystem_i.ex_ready_i),
    .id_valid_i        (id_subsystem_i.id_valid_o),
    .ex_unit_i         (id_subsystem_i.ex_unit_o),
    .ex_sys_op_i       (id_subsystem_i.ex_sys_op_o),
    .ex_csr_op_i       (id_subsystem_i.ex_csr_op_o),
    .ex_lsu_we_i       (id_subsystem_i.ex_lsu_we_o),
    .ex_rf_we_i        (id_subsystem_i.ex_rf_we_o),
    .ex_rd_i           (id_subsystem_i.ex_rd_o),
    .ex_operand_a_i    (id_subsystem_i.ex_operand_a_o),
    .ex_operand_b_i    (id_subsystem_i.ex_operand_b_o),
    .ex_illegal_i      (id_subsystem_i.ex_illegal_o),
    .exp_unit_i        (exp_unit),
    .exp_sys_op_i      (exp_sys_op),
    .exp_csr_op_i      (exp_csr_op),
    .exp_illegal_i     (exp_illegal),
    .idle_o            (mon_idle),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors)
  );

  ////////////////////////////////////////////////////////////
  // Random EX back-pressure
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  always @(posedge clk) begin
    #1;
    lfsr = lfsr_step(lfsr);
    ex_ready_i = lfsr[0];
  end

  ////////////////////////////////////////////////////////////
  // Drivers, each entered and left 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic send_word(input logic [31:0] word, input logic dummy);
    instr_i       = word;
    dummy_i       = dummy;
    instr_valid_i = 1'b1;
    @(posedge clk);
    while (!id_ready_o) @(posedge clk);
    #1;
    instr_valid_i = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    while (!mon_idle) begin
      @(posedge clk);
      #1;
    end
    wb_we_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    @(posedge clk);
    #1;
    wb_we_i = 1'b0;
  endtask

  task automatic hold_halt(input int cycles);
    halt_i = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
    halt_i = 1'b0;
  endtask

  task automatic pulse_kill();
    kill_i = 1'b1;
    @(posedge clk);
    #1;
    kill_i = 1'b0;
  endtask

  task automatic stop_on_timeout(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          lines;
    int          drain;
    string       text;
    logic [31:0] kind;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] f_unit;
    logic [31:0] f_sys;
    logic [31:0] f_csr;
    logic [31:0] f_ill;
    lines = 0;
    fd = $fopen("sim/id_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file sim/id_stimulus.txt");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      while ($fgets(text, fd)) begin
        if (text.len() > 1 && text[0] != "#") lines++;
      end
      $fclose(fd);
      fork
        stop_on_timeout(lines * 20 + 100);
      join_none
      repeat (5) @(posedge clk);
      #1;
      reset_i = 1'b0;
      fd = $fopen("sim/id_stimulus.txt", "r");
      while ($fgets(text, fd)) begin
        if (text.len() > 1 && text[0] != "#") begin
          if ($sscanf(text, "%h %h %h %h %h %h %h", kind, a1, a2, f_unit, f_sys,
                      f_csr, f_ill) != 7) begin
            tb_errors++;
            $display("Malformed stimulus line: %s", text);
          end else begin
            exp_unit    = f_unit[2:0];
            exp_sys_op  = f_sys[2:0];
            exp_csr_op  = f_csr[1:0];
            exp_illegal = f_ill[0];
            case (kind)
              0: write_reg(a1[4:0], a2);
              1: send_word(a1, a2[0]);
              2: hold_halt(a1);
              3: pulse_kill();
              default: begin
                tb_errors++;
                $display("Unknown stimulus kind %0d", kind);
              end
            endcase
          end
        end
      end
      $fclose(fd);
      // At most two words are in flight, so they leave well within this bound
      drain = 0;
      while (!mon_idle && drain < 100) begin
        @(posedge clk);
        drain++;
      end
      repeat (4) @(posedge clk);
      id_monitor_i.check_drained();
      $display("Errors: value %0d, protocol %0d, assertion %0d, testbench %0d",
               value_errors, protocol_errors,
               id_subsystem_i.id_stage_i.id_stage_checker_i.fail_count, tb_errors);
      if (value_errors + protocol_errors + tb_errors +
          id_subsystem_i.id_stage_i.id_stage_checker_i.fail_count == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/id_pkg.sv
verilog/decode_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/id_stage.sv
verilog/id_subsystem.sv
sim/id_stage_checker.sv
sim/id_monitor.sv
sim/id_subsystem_tb.sv

// File: verilog/decode_if.sv
// Decoded control from the decoder to the stage. Purely combinational, so it carries no clock.
`default_nettype none
`timescale 1ns/1ps

interface decode_if;

  id_pkg::unit_e                unit;
  id_pkg::sys_op_e              sys_op;
  id_pkg::csr_op_e              csr_op;
  logic                         lsu_we;
  logic                         rf_we;
  logic [id_pkg::REG_AW-1:0]    rs1;
  logic [id_pkg::REG_AW-1:0]    rs2;
  logic [id_pkg::REG_AW-1:0]    rd;
  // Operand B takes imm instead of the rs2 read data
  logic                         use_imm;
  logic [id_pkg::XLEN-1:0]      imm;
  logic                         illegal;

  // Decoder side
  modport dec (
    output unit, sys_op, csr_op, lsu_we, rf_we, rs1, rs2, rd, use_imm, imm, illegal
  );

  // Pipeline stage side
  modport stage (
    input unit, sys_op, csr_op, lsu_we, rf_we, rs1, rs2, rd, use_imm, imm, illegal
  );

endinterface

`default_nettype wire

// File: verilog/id_pkg.sv
// Shared widths, opcode and control encodings, and pipeline register layouts for decode.
// Only the RV32I subset listed in opcode_e is recognized. Every other major opcode is illegal.
`default_nettype none

package id_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int XLEN           = 32;
  localparam int NUM_REGS       = 32;
  localparam int NUM_READ_PORTS = 2;
  // Register address width follows from the register count
  localparam int REG_AW         = $clog2(NUM_REGS);

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    OP       = 7'h33,
    OP_IMM   = 7'h13,
    LOAD     = 7'h03,
    STORE    = 7'h23,
    SYSTEM   = 7'h73,
    MISC_MEM = 7'h0f,
    LUI      = 7'h37
  } opcode_e;

  // CSR_OP_READ doubles as the idle value when no CSR is touched
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  typedef enum logic [2:0] {
    SYS_NONE   = 3'd0,
    SYS_ECALL  = 3'd1,
    SYS_EBREAK = 3'd2,
    SYS_MRET   = 3'd3,
    SYS_WFI    = 3'd4,
    SYS_FENCEI = 3'd5
  } sys_op_e;

  // A single unit code, so at most one unit is ever enabled
  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_ALU  = 3'd1,
    UNIT_MUL  = 3'd2,
    UNIT_DIV  = 3'd3,
    UNIT_CSR  = 3'd4,
    UNIT_SYS  = 3'd5,
    UNIT_LSU  = 3'd6
  } unit_e;

  ////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic            valid;
    logic            dummy;
  } if_id_t;

  typedef struct packed {
    unit_e             unit;
    sys_op_e           sys_op;
    csr_op_e           csr_op;
    logic              lsu_we;
    logic              rf_we;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   operand_a;
    logic [XLEN-1:0]   operand_b;
    logic              illegal;
  } id_ex_t;

endpackage

`default_nettype wire

// File: verilog/id_stage.sv
// IF/ID plus ID/EX registers with valid/ready on both sides. No hazard checks or forwarding.
// A word handshaken while kill_i is high is flushed along with the words already held.
`default_nettype none
`timescale 1ns/1ps

module id_stage (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic [id_pkg::XLEN-1:0]   instr_i,
  input  logic                      instr_valid_i,
  input  logic                      dummy_i,
  output logic                      id_ready_o,
  input  logic                      halt_i,
  input  logic                      kill_i,
  output logic [id_pkg::XLEN-1:0]   instr_o,
  decode_if.stage                   dec,
  output logic [id_pkg::REG_AW-1:0] raddr_o [id_pkg::NUM_READ_PORTS],
  input  logic [id_pkg::XLEN-1:0]   rdata_i [id_pkg::NUM_READ_PORTS],
  output id_pkg::id_ex_t            id_ex_o,
  output logic                      id_valid_o,
  input  logic                      ex_ready_i
);

  id_pkg::if_id_t if_id_q;
  id_pkg::id_ex_t id_ex_q;
  id_pkg::id_ex_t id_ex_d;
  logic           id_valid_q;

  logic           run;
  logic           advance;
  logic           if_id_load;

  ////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////

  // Kill wins over halt, and either one freezes normal flow
  assign run = !halt_i && !kill_i;

  // IF/ID moves on when ID/EX is empty or being drained this cycle
  assign advance    = run && if_id_q.valid && (!id_valid_q || ex_ready_i);
  assign if_id_load = run && instr_valid_i && (!if_id_q.valid || advance);

  // Ready only drops when both registers are full and EX is stalled
  assign id_ready_o = kill_i || (run && (!if_id_q.valid || !id_valid_q || ex_ready_i));
  assign id_valid_o = run && id_valid_q;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  assign instr_o    = if_id_q.instr;
  assign raddr_o[0] = dec.rs1;
  assign raddr_o[1] = dec.rs2;

  always_comb begin
    id_ex_d.unit    = dec.unit;
    id_ex_d.sys_op  = dec.sys_op;
    id_ex_d.csr_op  = dec.csr_op;
    id_ex_d.lsu_we  = dec.lsu_we;
    id_ex_d.rf_we   = dec.rf_we;
    id_ex_d.rd      = dec.rd;
    id_ex_d.illegal = dec.illegal;

    // Ordinary words see zero in register 0, dummies see what is stored there
    if (dec.rs1 == '0 && !if_id_q.dummy) begin
      id_ex_d.operand_a = '0;
    end else begin
      id_ex_d.operand_a = rdata_i[0];
    end

    if (dec.use_imm) begin
      id_ex_d.operand_b = dec.imm;
    end else if (dec.rs2 == '0 && !if_id_q.dummy) begin
      id_ex_d.operand_b = '0;
    end else begin
      id_ex_d.operand_b = rdata_i[1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_id_q.valid <= 1'b0;
      id_valid_q    <= 1'b0;
    end else if (kill_i) begin
      // Flush both stages
      if_id_q.valid <= 1'b0;
      id_valid_q    <= 1'b0;
    end else if (run) begin
      if (if_id_load) begin
        if_id_q.instr <= instr_i;
        if_id_q.dummy <= dummy_i;
        if_id_q.valid <= 1'b1;
      end else if (advance) begin
        if_id_q.valid <= 1'b0;
      end

      if (advance) begin
        id_ex_q    <= id_ex_d;
        id_valid_q <= 1'b1;
      end else if (ex_ready_i) begin
        // EX took the result and nothing new follows
        id_valid_q <= 1'b0;
      end
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: verilog/id_subsystem.sv
// Decode subsystem top. No registers beyond the stage, so its timing equals id_stage timing.
`default_nettype none
`timescale 1ns/1ps

module id_subsystem (
  input  logic                      clk,
  input  logic                      reset_i,
  // Fetch side
  input  logic [id_pkg::XLEN-1:0]   instr_i,
  input  logic                      instr_valid_i,
  input  logic                      dummy_i,
  output logic                      id_ready_o,
  // Controller
  input  logic                      halt_i,
  input  logic                      kill_i,
  // Writeback into the register file
  input  logic                      wb_we_i,
  input  logic [id_pkg::REG_AW-1:0] wb_addr_i,
  input  logic [id_pkg::XLEN-1:0]   wb_data_i,
  // Execute side
  input  logic                      ex_ready_i,
  output logic                      id_valid_o,
  output id_pkg::unit_e             ex_unit_o,
  output id_pkg::sys_op_e           ex_sys_op_o,
  output id_pkg::csr_op_e           ex_csr_op_o,
  output logic                      ex_lsu_we_o,
  output logic                      ex_rf_we_o,
  output logic [id_pkg::REG_AW-1:0] ex_rd_o,
  output logic [id_pkg::XLEN-1:0]   ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0]   ex_operand_b_o,
  output logic                      ex_illegal_o
);

  logic [id_pkg::XLEN-1:0]   instr_dec;
  logic [id_pkg::REG_AW-1:0] rf_raddr [id_pkg::NUM_READ_PORTS];
  logic [id_pkg::XLEN-1:0]   rf_rdata [id_pkg::NUM_READ_PORTS];
  id_pkg::id_ex_t            id_ex;

  decode_if dec_if ();

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  instr_decoder instr_decoder_i (
    .instr_i (instr_dec),
    .dec     (dec_if.dec)
  );

  // Writeback goes straight in, register 0 included
  reg_file reg_file_i (
    .clk     (clk),
    .reset_i (reset_i),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (wb_we_i),
    .waddr_i (wb_addr_i),
    .wdata_i (wb_data_i)
  );

  id_stage id_stage_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .dummy_i       (dummy_i),
    .id_ready_o    (id_ready_o),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .instr_o       (instr_dec),
    .dec           (dec_if.stage),
    .raddr_o       (rf_raddr),
    .rdata_i       (rf_rdata),
    .id_ex_o       (id_ex),
    .id_valid_o    (id_valid_o),
    .ex_ready_i    (ex_ready_i)
  );

  // Flatten the ID/EX register onto plain ports
  assign ex_unit_o      = id_ex.unit;
  assign ex_sys_op_o    = id_ex.sys_op;
  assign ex_csr_op_o    = id_ex.csr_op;
  assign ex_lsu_we_o    = id_ex.lsu_we;
  assign ex_rf_we_o     = id_ex.rf_we;
  assign ex_rd_o        = id_ex.rd;
  assign ex_operand_a_o = id_ex.operand_a;
  assign ex_operand_b_o = id_ex.operand_b;
  assign ex_illegal_o   = id_ex.illegal;

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
// Purely combinational RV32 decoder. CSR access takes register forms only, so CSRRxI is illegal.
// FENCE decodes as a legal no-op with no unit. Store data from rs2 is not carried to EX.
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  decode_if.dec                   dec
);

  ////////////////////////////////////////////////////////////
  // Instruction fields and immediates
  ////////////////////////////////////////////////////////////

  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_csr;

  assign funct3  = instr_i[14:12];
  assign funct7  = instr_i[31:25];
  assign imm_i   = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u   = {instr_i[31:12], 12'b0};
  // The CSR address rides on operand B, zero extended
  assign imm_csr = {20'b0, instr_i[31:20]};

  // Raw decode before the illegal override
  id_pkg::unit_e           unit_d;
  id_pkg::sys_op_e         sys_op_d;
  id_pkg::csr_op_e         csr_op_d;
  logic                    lsu_we_d;
  logic                    rf_we_d;
  logic                    use_imm_d;
  logic [id_pkg::XLEN-1:0] imm_d;
  logic                    illegal_d;

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    unit_d    = id_pkg::UNIT_NONE;
    sys_op_d  = id_pkg::SYS_NONE;
    csr_op_d  = id_pkg::CSR_OP_READ;
    lsu_we_d  = 1'b0;
    rf_we_d   = 1'b0;
    use_imm_d = 1'b0;
    imm_d     = '0;
    illegal_d = 1'b0;

    case (id_pkg::opcode_e'(instr_i[6:0]))
      id_pkg::OP: begin
        rf_we_d = 1'b1;
        // funct7 1 is the M extension, low half of funct3 multiplies
        if (funct7 == 7'h01) begin
          unit_d = funct3[2] ? id_pkg::UNIT_DIV : id_pkg::UNIT_MUL;
        end else if (funct7 == 7'h00) begin
          unit_d = id_pkg::UNIT_ALU;
        end else if (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)) begin
          // SUB and SRA
          unit_d = id_pkg::UNIT_ALU;
        end else begin
          illegal_d = 1'b1;
        end
      end
      id_pkg::OP_IMM: begin
        unit_d    = id_pkg::UNIT_ALU;
        rf_we_d   = 1'b1;
        use_imm_d = 1'b1;
        imm_d     = imm_i;
        // Shift immediates restrict the upper bits
        if (funct3 == 3'd1 && funct7 != 7'h00) begin
          illegal_d = 1'b1;
        end
        if (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20) begin
          illegal_d = 1'b1;
        end
      end
      id_pkg::LOAD: begin
        unit_d    = id_pkg::UNIT_LSU;
        rf_we_d   = 1'b1;
        use_imm_d = 1'b1;
        imm_d     = imm_i;
        // Only LB, LH, LW, LBU and LHU exist
        illegal_d = (funct3 == 3'd3) || (funct3[2:1] == 2'b11);
      end
      id_pkg::STORE: begin
        unit_d    = id_pkg::UNIT_LSU;
        lsu_we_d  = 1'b1;
        use_imm_d = 1'b1;
        imm_d     = imm_s;
        illegal_d = (funct3 > 3'd2);
      end
      id_pkg::LUI: begin
        unit_d    = id_pkg::UNIT_ALU;
        rf_we_d   = 1'b1;
        use_imm_d = 1'b1;
        imm_d     = imm_u;
      end
      id_pkg::MISC_MEM: begin
        if (funct3 == 3'd1) begin
          unit_d   = id_pkg::UNIT_SYS;
          sys_op_d = id_pkg::SYS_FENCEI;
        end else if (funct3 != 3'd0) begin
          illegal_d = 1'b1;
        end
      end
      id_pkg::SYSTEM: begin
        if (funct3 == 3'd0) begin
          unit_d = id_pkg::UNIT_SYS;
          // Privileged words need zero rs1 and rd fields
          if (instr_i[19:7] != '0) begin
            illegal_d = 1'b1;
          end
          case (instr_i[31:20])
            12'h000: sys_op_d = id_pkg::SYS_ECALL;
            12'h001: sys_op_d = id_pkg::SYS_EBREAK;
            12'h302: sys_op_d = id_pkg::SYS_MRET;
            12'h105: sys_op_d = id_pkg::SYS_WFI;
            default: illegal_d = 1'b1;
          endcase
        end else if (!funct3[2]) begin
          unit_d    = id_pkg::UNIT_CSR;
          rf_we_d   = 1'b1;
          use_imm_d = 1'b1;
          imm_d     = imm_csr;
          // CSRRS and CSRRC with rs1 of zero only read the CSR
          if (funct3[1:0] == 2'b01) begin
            csr_op_d = id_pkg::CSR_OP_WRITE;
          end else if (instr_i[19:15] == '0) begin
            csr_op_d = id_pkg::CSR_OP_READ;
          end else begin
            csr_op_d = funct3[0] ? id_pkg::CSR_OP_CLEAR : id_pkg::CSR_OP_SET;
          end
        end else begin
          illegal_d = 1'b1;
        end
      end
      default: illegal_d = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Outputs with illegal words stripped of side effects
  ////////////////////////////////////////////////////////////

  assign dec.unit    = illegal_d ? id_pkg::UNIT_NONE : unit_d;
  assign dec.sys_op  = illegal_d ? id_pkg::SYS_NONE : sys_op_d;
  assign dec.csr_op  = illegal_d ? id_pkg::CSR_OP_READ : csr_op_d;
  assign dec.lsu_we  = lsu_we_d && !illegal_d;
  assign dec.rf_we   = rf_we_d && !illegal_d;
  assign dec.use_imm = use_imm_d;
  assign dec.imm     = imm_d;
  assign dec.illegal = illegal_d;

  // LUI reuses the rs1 field as immediate bits, so it reads register 0
  assign dec.rs1 = (instr_i[6:0] == id_pkg::LUI) ? '0 : instr_i[19:15];
  assign dec.rs2 = instr_i[24:20];
  assign dec.rd  = instr_i[11:7];

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// Register 0 is a normal storage entry here. Zeroing for ordinary reads happens in the stage.
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic [id_pkg::REG_AW-1:0] raddr_i [id_pkg::NUM_READ_PORTS],
  output logic [id_pkg::XLEN-1:0]   rdata_o [id_pkg::NUM_READ_PORTS],
  input  logic                      we_i,
  input  logic [id_pkg::REG_AW-1:0] waddr_i,
  input  logic [id_pkg::XLEN-1:0]   wdata_i
);

  logic [id_pkg::XLEN-1:0] regs_q [id_pkg::NUM_REGS];

  // Single write port, no bypass to the read ports
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < id_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads, so a write shows up in the cycle after its edge
  always_comb begin
    for (int p = 0; p < id_pkg::NUM_READ_PORTS; p++) begin
      rdata_o[p] = regs_q[raddr_i[p]];
    end
  end

endmodule

`default_nettype wire
